// ==== common/soc_map_pkg.sv ====
`default_nettype none

package soc_map_pkg;

    // word addresses seen on the wishbone port.
    localparam logic [31:0] RAM_BASE   = 32'h0000_0000;
    localparam logic [31:0] SEG7_ADDR  = 32'h0000_0400;
    localparam logic [31:0] VIDEO_ADDR = 32'h0000_0410;
    localparam logic [31:0] TEXT_BASE  = 32'h0000_0800;

    // data memory depth in words.
    localparam int unsigned RAM_WORDS = 1024;

    // text screen geometry.
    localparam int unsigned TEXT_COLS  = 80;
    localparam int unsigned TEXT_ROWS  = 40;
    localparam int unsigned TEXT_WORDS = TEXT_COLS * TEXT_ROWS;

    // register values after reset.
    localparam logic [7:0] VIDEO_CTL_DEFAULT  = 8'hF7;
    localparam logic [7:0] CURSOR_COL_DEFAULT = 8'd1;
    localparam logic [7:0] CURSOR_ROW_DEFAULT = 8'd0;

    // digit scan counter width, top two bits pick the digit.
    localparam int unsigned SEG7_SCAN_BITS = 4;

endpackage

`default_nettype wire

// ==== common/soc_types_pkg.sv ====
`default_nettype none

package soc_types_pkg;

    // bus data and word address.
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // text memory entries and their index.
    typedef logic [7:0]  char_t;
    typedef logic [11:0] text_addr_t;

    // control register payloads.
    typedef logic [7:0] video_ctl_t;
    typedef logic [6:0] cursor_col_t;
    typedef logic [5:0] cursor_row_t;

    // display lines, both active low; bit 7 of seg is the decimal point.
    typedef logic [7:0] seg_t;
    typedef logic [3:0] an_t;

endpackage

`default_nettype wire

// ==== src/bus_decode.sv ====
`default_nettype none

module bus_decode (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 cyc,
    input  wire logic                 stb,
    input  wire soc_types_pkg::addr_t adr,
    output logic                      ram_stb,
    output logic                      seg7_stb,
    output logic                      ctl_stb,
    output logic                      col_stb,
    output logic                      row_stb,
    output logic                      text_stb,
    output soc_types_pkg::addr_t      off,
    input  wire logic                 ram_ack,
    input  wire logic                 seg7_ack,
    input  wire logic                 ctl_ack,
    input  wire logic                 col_ack,
    input  wire logic                 row_ack,
    input  wire logic                 text_ack,
    input  wire soc_types_pkg::word_t ram_dat,
    input  wire soc_types_pkg::word_t seg7_dat,
    input  wire soc_types_pkg::word_t ctl_dat,
    input  wire soc_types_pkg::word_t col_dat,
    input  wire soc_types_pkg::word_t row_dat,
    input  wire soc_types_pkg::word_t text_dat,
    output soc_types_pkg::word_t      dat_r,
    output logic                      ack
);

    soc_types_pkg::addr_t ram_rel;
    soc_types_pkg::addr_t text_rel;
    logic in_ram;
    logic in_seg7;
    logic in_ctl;
    logic in_col;
    logic in_row;
    logic in_text;
    logic in_none;
    logic req;
    logic none_ack;
    logic [5:0] sel_q;

    // unsigned wrap makes each range check a single compare.
    assign ram_rel  = adr - soc_map_pkg::RAM_BASE;
    assign text_rel = adr - soc_map_pkg::TEXT_BASE;
    assign in_ram   = ram_rel < soc_map_pkg::RAM_WORDS;
    assign in_text  = text_rel < soc_map_pkg::TEXT_WORDS;
    assign in_seg7  = adr == soc_map_pkg::SEG7_ADDR;
    assign in_ctl   = adr == soc_map_pkg::VIDEO_ADDR;
    assign in_col   = adr == soc_map_pkg::VIDEO_ADDR + 32'd1;
    assign in_row   = adr == soc_map_pkg::VIDEO_ADDR + 32'd2;
    assign in_none  = !(in_ram || in_text || in_seg7 || in_ctl || in_col || in_row);

    assign req      = cyc && stb;
    assign ram_stb  = req && in_ram;
    assign seg7_stb = req && in_seg7;
    assign ctl_stb  = req && in_ctl;
    assign col_stb  = req && in_col;
    assign row_stb  = req && in_row;
    assign text_stb = req && in_text;
    assign off      = in_text ? text_rel : ram_rel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel_q    <= '0;
            none_ack <= 1'b0;
        end else begin
            sel_q    <= req ? {in_text, in_row, in_col, in_ctl, in_seg7, in_ram} : 6'b0;
            // unmapped accesses complete here, write data dropped.
            none_ack <= req && in_none && !none_ack;
        end
    end

    assign ack = ram_ack || seg7_ack || ctl_ack || col_ack || row_ack || text_ack || none_ack;

    // and-or mux, zero when nothing selected.
    always_comb begin
        dat_r = '0;
        if (sel_q[0]) dat_r = dat_r | ram_dat;
        if (sel_q[1]) dat_r = dat_r | seg7_dat;
        if (sel_q[2]) dat_r = dat_r | ctl_dat;
        if (sel_q[3]) dat_r = dat_r | col_dat;
        if (sel_q[4]) dat_r = dat_r | row_dat;
        if (sel_q[5]) dat_r = dat_r | text_dat;
    end

    a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ram_ack, seg7_ack, ctl_ack, col_ack, row_ack, text_ack, none_ack}));

    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        ack |=> !ack);

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`default_nettype none

module data_ram (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire soc_types_pkg::addr_t off,
    input  wire soc_types_pkg::word_t dat_w,
    output soc_types_pkg::word_t      dat_r,
    output logic                      ack
);

    localparam int unsigned AW = $clog2(soc_map_pkg::RAM_WORDS);

    soc_types_pkg::word_t mem [soc_map_pkg::RAM_WORDS];
    logic [AW-1:0] idx;

    assign idx = off[AW-1:0];

    // one access per request, the ack cycle is ignored.
    always_ff @(posedge clk) begin
        if (stb && !ack) begin
            if (we) begin
                mem[idx] <= dat_w;
            end
            dat_r <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= stb && !ack;
        end
    end

endmodule

`default_nettype wire

// ==== src/mmr.sv ====
`default_nettype none

module mmr #(
    parameter type      payload_t = logic [7:0],
    parameter payload_t DEFAULT   = '0
) (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire soc_types_pkg::word_t dat_w,
    output soc_types_pkg::word_t      dat_r,
    output logic                      ack,
    output payload_t                  val
);

    localparam int unsigned W = $bits(payload_t);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            val <= DEFAULT;
            ack <= 1'b0;
        end else begin
            ack <= stb && !ack;
            // low bits of the bus word only.
            if (stb && we && !ack) begin
                val <= payload_t'(dat_w[W-1:0]);
            end
        end
    end

    // readback, zero-extended.
    always_comb begin
        dat_r = '0;
        dat_r[W-1:0] = val;
    end

endmodule

`default_nettype wire

// ==== src/text_ram.sv ====
`default_nettype none

module text_ram (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      stb,
    input  wire logic                      we,
    input  wire soc_types_pkg::addr_t      off,
    input  wire soc_types_pkg::word_t      dat_w,
    output soc_types_pkg::word_t           dat_r,
    output logic                           ack,
    input  wire soc_types_pkg::text_addr_t scan_addr,
    output soc_types_pkg::char_t           scan_data
);

    localparam int unsigned CW = $bits(soc_types_pkg::char_t);
    localparam int unsigned AW = $bits(soc_types_pkg::text_addr_t);

    soc_types_pkg::char_t mem [soc_map_pkg::TEXT_WORDS];
    soc_types_pkg::text_addr_t idx;
    soc_types_pkg::char_t rd_q;

    assign idx = off[AW-1:0];

    // bus side.
    always_ff @(posedge clk) begin
        if (stb && !ack) begin
            if (we) begin
                mem[idx] <= dat_w[CW-1:0];
            end
            rd_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else begin
            ack <= stb && !ack;
        end
    end

    always_comb begin
        dat_r = '0;
        dat_r[CW-1:0] = rd_q;
    end

    // renderer side, read only and always enabled.
    always_ff @(posedge clk) begin
        scan_data <= mem[scan_addr];
    end

    a_off_range: assert property (@(posedge clk) disable iff (!rst_n)
        stb |-> off < soc_map_pkg::TEXT_WORDS);

endmodule

`default_nettype wire

// ==== seg7/seg7_driver.sv ====
`default_nettype none

module seg7_driver (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 stb,
    input  wire logic                 we,
    input  wire soc_types_pkg::word_t dat_w,
    output soc_types_pkg::word_t      dat_r,
    output logic                      ack,
    output soc_types_pkg::seg_t       seg,
    output soc_types_pkg::an_t        an
);

    localparam int unsigned SB = soc_map_pkg::SEG7_SCAN_BITS;

    logic [15:0]   value_q;
    logic [SB-1:0] scan_q;
    logic          scan_on;
    logic          step;
    logic [1:0]    digit;
    logic [3:0]    nibble;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value_q <= '0;
            ack     <= 1'b0;
        end else begin
            ack <= stb && !ack;
            if (stb && we && !ack) begin
                value_q <= dat_w[15:0];
            end
        end
    end

    always_comb begin
        dat_r = '0;
        dat_r[15:0] = value_q;
    end

    // digit changes when the low counter bits wrap.
    assign step  = &scan_q[SB-3:0];
    assign digit = scan_q[SB-1 -: 2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_q  <= '0;
            scan_on <= 1'b0;
        end else begin
            scan_q  <= scan_q + 1'b1;
            scan_on <= scan_on || step;
        end
    end

    // dark until the first step.
    assign an = scan_on ? ~(soc_types_pkg::an_t'(1) << digit) : '1;

    assign nibble = value_q[{digit, 2'b00} +: 4];

    // active-low segments in gfedcba order.
    always_comb begin
        seg[7] = 1'b1;
        case (nibble)
            4'h0: seg[6:0] = 7'b1000000;
            4'h1: seg[6:0] = 7'b1111001;
            4'h2: seg[6:0] = 7'b0100100;
            4'h3: seg[6:0] = 7'b0110000;
            4'h4: seg[6:0] = 7'b0011001;
            4'h5: seg[6:0] = 7'b0010010;
            4'h6: seg[6:0] = 7'b0000010;
            4'h7: seg[6:0] = 7'b1111000;
            4'h8: seg[6:0] = 7'b0000000;
            4'h9: seg[6:0] = 7'b0010000;
            4'hA: seg[6:0] = 7'b0001000;
            4'hB: seg[6:0] = 7'b0000011;
            4'hC: seg[6:0] = 7'b1000110;
            4'hD: seg[6:0] = 7'b0100001;
            4'hE: seg[6:0] = 7'b0000110;
            default: seg[6:0] = 7'b0001110;
        endcase
    end

    // the lit digit moves up one place at each step.
    a_digit_step: assert property (@(posedge clk) disable iff (!rst_n)
        scan_on && step |=> an == $past({an[2:0], an[3]}));

endmodule

`default_nettype wire

// ==== src/periph_top.sv ====
`default_nettype none

module periph_top (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      cyc,
    input  wire logic                      stb,
    input  wire logic                      we,
    input  wire soc_types_pkg::addr_t      adr,
    input  wire soc_types_pkg::word_t      dat_w,
    output soc_types_pkg::word_t           dat_r,
    output logic                           ack,
    output soc_types_pkg::seg_t            seg,
    output soc_types_pkg::an_t             an,
    output soc_types_pkg::video_ctl_t      video_ctl,
    output soc_types_pkg::cursor_col_t     cursor_col,
    output soc_types_pkg::cursor_row_t     cursor_row,
    input  wire soc_types_pkg::text_addr_t scan_addr,
    output soc_types_pkg::char_t           scan_data
);

    logic ram_stb, seg7_stb, ctl_stb, col_stb, row_stb, text_stb;
    logic ram_ack, seg7_ack, ctl_ack, col_ack, row_ack, text_ack;
    soc_types_pkg::addr_t off;
    soc_types_pkg::word_t ram_dat, seg7_dat, ctl_dat, col_dat, row_dat, text_dat;

    bus_decode decode_i (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .adr(adr),
        .ram_stb(ram_stb), .seg7_stb(seg7_stb), .ctl_stb(ctl_stb),
        .col_stb(col_stb), .row_stb(row_stb), .text_stb(text_stb), .off(off),
        .ram_ack(ram_ack), .seg7_ack(seg7_ack), .ctl_ack(ctl_ack),
        .col_ack(col_ack), .row_ack(row_ack), .text_ack(text_ack),
        .ram_dat(ram_dat), .seg7_dat(seg7_dat), .ctl_dat(ctl_dat),
        .col_dat(col_dat), .row_dat(row_dat), .text_dat(text_dat),
        .dat_r(dat_r), .ack(ack)
    );

    data_ram ram_i (
        .clk(clk), .rst_n(rst_n), .stb(ram_stb), .we(we), .off(off),
        .dat_w(dat_w), .dat_r(ram_dat), .ack(ram_ack)
    );

    seg7_driver seg7_i (
        .clk(clk), .rst_n(rst_n), .stb(seg7_stb), .we(we), .dat_w(dat_w),
        .dat_r(seg7_dat), .ack(seg7_ack), .seg(seg), .an(an)
    );

    // video control, cursor column, cursor row.
    mmr #(
        .payload_t(soc_types_pkg::video_ctl_t),
        .DEFAULT(soc_types_pkg::video_ctl_t'(soc_map_pkg::VIDEO_CTL_DEFAULT))
    ) video_ctl_i (
        .clk(clk), .rst_n(rst_n), .stb(ctl_stb), .we(we), .dat_w(dat_w),
        .dat_r(ctl_dat), .ack(ctl_ack), .val(video_ctl)
    );

    mmr #(
        .payload_t(soc_types_pkg::cursor_col_t),
        .DEFAULT(soc_types_pkg::cursor_col_t'(soc_map_pkg::CURSOR_COL_DEFAULT))
    ) cursor_col_i (
        .clk(clk), .rst_n(rst_n), .stb(col_stb), .we(we), .dat_w(dat_w),
        .dat_r(col_dat), .ack(col_ack), .val(cursor_col)
    );

    mmr #(
        .payload_t(soc_types_pkg::cursor_row_t),
        .DEFAULT(soc_types_pkg::cursor_row_t'(soc_map_pkg::CURSOR_ROW_DEFAULT))
    ) cursor_row_i (
        .clk(clk), .rst_n(rst_n), .stb(row_stb), .we(we), .dat_w(dat_w),
        .dat_r(row_dat), .ack(row_ack), .val(cursor_row)
    );

    text_ram text_i (
        .clk(clk), .rst_n(rst_n), .stb(text_stb), .we(we), .off(off),
        .dat_w(dat_w), .dat_r(text_dat), .ack(text_ack),
        .scan_addr(scan_addr), .scan_data(scan_data)
    );

endmodule

`default_nettype wire

// ==== bench/periph_tb.sv ====
`default_nettype none

module periph_tb;

    localparam int unsigned ACK_LIMIT  = 20;
    localparam int unsigned SCAN_LIMIT = 64;
    localparam int unsigned N_RAM      = 24;
    localparam int unsigned N_TEXT     = 16;
    localparam int unsigned RAM_AW     = $clog2(soc_map_pkg::RAM_WORDS);

    logic                        clk;
    logic                        rst_n;
    logic                        cyc;
    logic                        stb;
    logic                        we;
    soc_types_pkg::addr_t        adr;
    soc_types_pkg::word_t        dat_w;
    soc_types_pkg::word_t        dat_r;
    logic                        ack;
    soc_types_pkg::seg_t         seg;
    soc_types_pkg::an_t          an;
    soc_types_pkg::video_ctl_t   video_ctl;
    soc_types_pkg::cursor_col_t  cursor_col;
    soc_types_pkg::cursor_row_t  cursor_row;
    soc_types_pkg::text_addr_t   scan_addr;
    soc_types_pkg::char_t        scan_data;

    // model of everything the bus can reach.
    soc_types_pkg::word_t        ram_model [soc_map_pkg::RAM_WORDS];
    soc_types_pkg::char_t        text_model [soc_map_pkg::TEXT_WORDS];
    soc_types_pkg::video_ctl_t   ctl_model;
    soc_types_pkg::cursor_col_t  col_model;
    soc_types_pkg::cursor_row_t  row_model;
    logic [15:0]                 seg7_model;

    soc_types_pkg::word_t        exp_q [$];
    soc_types_pkg::addr_t        exp_adr_q [$];
    soc_types_pkg::addr_t        ram_adrs [$];
    soc_types_pkg::text_addr_t   text_pos [$];
    soc_types_pkg::addr_t        holes [4] = '{soc_map_pkg::SEG7_ADDR + 32'd1,
        soc_map_pkg::VIDEO_ADDR + 32'd3, soc_map_pkg::TEXT_BASE + soc_map_pkg::TEXT_WORDS,
        32'h8000_0000};
    int unsigned                 errors;
    int unsigned                 errors_at_start;
    int unsigned                 tests_run;
    int unsigned                 tests_failed;
    string                       test_name;

    periph_top dut_i (
        .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .seg(seg), .an(an),
        .video_ctl(video_ctl), .cursor_col(cursor_col), .cursor_row(cursor_row),
        .scan_addr(scan_addr), .scan_data(scan_data)
    );

    always #2 clk = ~clk;

    function automatic logic is_ram(input soc_types_pkg::addr_t a);
        return a >= soc_map_pkg::RAM_BASE && a < soc_map_pkg::RAM_BASE + soc_map_pkg::RAM_WORDS;
    endfunction

    function automatic logic is_text(input soc_types_pkg::addr_t a);
        return a >= soc_map_pkg::TEXT_BASE
            && a < soc_map_pkg::TEXT_BASE + soc_map_pkg::TEXT_WORDS;
    endfunction

    // unmapped writes fall through and change nothing.
    function automatic void ref_write(input soc_types_pkg::addr_t a,
                                      input soc_types_pkg::word_t d);
        if (is_ram(a)) begin
            ram_model[RAM_AW'(a - soc_map_pkg::RAM_BASE)] = d;
        end else if (is_text(a)) begin
            text_model[soc_types_pkg::text_addr_t'(a - soc_map_pkg::TEXT_BASE)] =
                soc_types_pkg::char_t'(d);
        end else if (a == soc_map_pkg::SEG7_ADDR) begin
            seg7_model = d[15:0];
        end else if (a == soc_map_pkg::VIDEO_ADDR) begin
            ctl_model = soc_types_pkg::video_ctl_t'(d);
        end else if (a == soc_map_pkg::VIDEO_ADDR + 32'd1) begin
            col_model = soc_types_pkg::cursor_col_t'(d);
        end else if (a == soc_map_pkg::VIDEO_ADDR + 32'd2) begin
            row_model = soc_types_pkg::cursor_row_t'(d);
        end
    endfunction

    function automatic soc_types_pkg::word_t ref_read(input soc_types_pkg::addr_t a);
        soc_types_pkg::word_t r;
        r = '0;
        if (is_ram(a)) begin
            r = ram_model[RAM_AW'(a - soc_map_pkg::RAM_BASE)];
        end else if (is_text(a)) begin
            r = soc_types_pkg::word_t'(
                text_model[soc_types_pkg::text_addr_t'(a - soc_map_pkg::TEXT_BASE)]);
        end else if (a == soc_map_pkg::SEG7_ADDR) begin
            r = soc_types_pkg::word_t'(seg7_model);
        end else if (a == soc_map_pkg::VIDEO_ADDR) begin
            r = soc_types_pkg::word_t'(ctl_model);
        end else if (a == soc_map_pkg::VIDEO_ADDR + 32'd1) begin
            r = soc_types_pkg::word_t'(col_model);
        end else if (a == soc_map_pkg::VIDEO_ADDR + 32'd2) begin
            r = soc_types_pkg::word_t'(row_model);
        end
        return r;
    endfunction

    // lit segments in gfedcba order before inversion.
    function automatic soc_types_pkg::seg_t seg_pattern(input logic [3:0] h);
        logic [6:0] lit;
        case (h)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return {1'b1, ~lit};
    endfunction

    task automatic check_word(input string what, input soc_types_pkg::word_t got,
                              input soc_types_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s returned %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_char(input string what, input soc_types_pkg::char_t got,
                              input soc_types_pkg::char_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s gave %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_seg(input string what, input soc_types_pkg::seg_t got_seg,
                             input soc_types_pkg::an_t got_an,
                             input soc_types_pkg::seg_t exp_seg,
                             input soc_types_pkg::an_t exp_an);
        if (got_seg !== exp_seg || got_an !== exp_an) begin
            errors++;
            $display("MISMATCH at %0t: %s seg %b an %b, expected seg %b an %b",
                     $time, what, got_seg, got_an, exp_seg, exp_an);
        end
    endtask

    task automatic check_ctl(input string what, input soc_types_pkg::video_ctl_t got_ctl,
                             input soc_types_pkg::cursor_col_t got_col,
                             input soc_types_pkg::cursor_row_t got_row);
        if (got_ctl !== ctl_model || got_col !== col_model || got_row !== row_model) begin
            errors++;
            $display("MISMATCH at %0t: %s ctl %h col %h row %h, expected %h %h %h", $time,
                     what, got_ctl, got_col, got_row, ctl_model, col_model, row_model);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("Testbench failed");
        $finish;
    endtask

    // starts and ends on a falling edge.
    task automatic bus_access(input soc_types_pkg::addr_t a, input logic wr,
                              input soc_types_pkg::word_t d);
        int unsigned n;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = d;
        n     = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ack && n < ACK_LIMIT);
        if (!ack) begin
            abort_run($sformatf("no ack for address %h within %0d cycles", a, ACK_LIMIT));
        end else begin
            if (n != 1) begin
                errors++;
                $display("ERROR at %0t: ack for address %h came after %0d cycles instead of 1",
                         $time, a, n);
            end
            cyc = 1'b0;
            stb = 1'b0;
            we  = 1'b0;
            @(negedge clk);
            if (ack) begin
                errors++;
                $display("ERROR at %0t: ack stayed high a second cycle for address %h",
                         $time, a);
            end
        end
    endtask

    task automatic bus_write(input soc_types_pkg::addr_t a, input soc_types_pkg::word_t d);
        ref_write(a, d);
        bus_access(a, 1'b1, d);
    endtask

    task automatic bus_read(input soc_types_pkg::addr_t a);
        exp_q.push_back(ref_read(a));
        exp_adr_q.push_back(a);
        bus_access(a, 1'b0, '0);
    endtask

    // read data is checked in the ack cycle.
    always @(negedge clk) begin
        if (rst_n && ack && exp_q.size() != 0) begin
            check_word($sformatf("read of %h", exp_adr_q.pop_front()), dat_r, exp_q.pop_front());
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        int unsigned          a;
        int                   k;
        int unsigned          n;
        logic [3:0]           seen;
        soc_types_pkg::word_t d;
        soc_types_pkg::an_t   exp_an;
        clk        = 1'b0;
        rst_n      = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        scan_addr  = '0;
        errors     = 0;
        tests_run  = 0;
        tests_failed = 0;
        ctl_model  = soc_types_pkg::video_ctl_t'(soc_map_pkg::VIDEO_CTL_DEFAULT);
        col_model  = soc_types_pkg::cursor_col_t'(soc_map_pkg::CURSOR_COL_DEFAULT);
        row_model  = soc_types_pkg::cursor_row_t'(soc_map_pkg::CURSOR_ROW_DEFAULT);
        seg7_model = '0;
        void'($urandom(63));
        repeat (10) @(negedge clk);

        start_test("reset defaults");
        check_seg("display in reset", seg, an, seg_pattern(4'h0), '1);
        rst_n = 1'b1;
        @(negedge clk);
        check_seg("display after reset", seg, an, seg_pattern(4'h0), '1);
        check_ctl("register outputs after reset", video_ctl, cursor_col, cursor_row);
        for (int i = 0; i < 3; i++) begin
            bus_read(soc_map_pkg::VIDEO_ADDR + soc_types_pkg::addr_t'(i));
        end
        finish_test();

        start_test("data ram");
        ram_adrs.push_back(soc_map_pkg::RAM_BASE);
        ram_adrs.push_back(soc_map_pkg::RAM_BASE + soc_map_pkg::RAM_WORDS - 1);
        for (int i = 0; i < N_RAM; i++) begin
            a = $urandom % soc_map_pkg::RAM_WORDS;
            ram_adrs.push_back(soc_map_pkg::RAM_BASE + a);
        end
        foreach (ram_adrs[i]) begin
            bus_write(ram_adrs[i], $urandom);
        end
        foreach (ram_adrs[i]) begin
            bus_read(ram_adrs[i]);
        end
        finish_test();

        start_test("control registers");
        for (int r = 0; r < 4; r++) begin
            for (int i = 0; i < 3; i++) begin
                bus_write(soc_map_pkg::VIDEO_ADDR + soc_types_pkg::addr_t'(i), $urandom);
            end
            check_ctl("register outputs", video_ctl, cursor_col, cursor_row);
            for (int i = 0; i < 3; i++) begin
                bus_read(soc_map_pkg::VIDEO_ADDR + soc_types_pkg::addr_t'(i));
            end
        end
        finish_test();

        start_test("text ram");
        for (int i = 0; i < N_TEXT; i++) begin
            text_pos.push_back(soc_types_pkg::text_addr_t'($urandom % soc_map_pkg::TEXT_WORDS));
            bus_write(soc_map_pkg::TEXT_BASE + text_pos[i], $urandom);
        end
        foreach (text_pos[i]) begin
            bus_read(soc_map_pkg::TEXT_BASE + text_pos[i]);
        end
        foreach (text_pos[i]) begin
            scan_addr = text_pos[i];
            @(negedge clk);
            check_char($sformatf("scan of %0d", text_pos[i]), scan_data,
                       text_model[text_pos[i]]);
        end
        finish_test();

        start_test("seven segment scan");
        d = $urandom;
        bus_write(soc_map_pkg::SEG7_ADDR, d);
        bus_read(soc_map_pkg::SEG7_ADDR);
        seen = '0;
        n    = 0;
        while (seen != 4'hF && n < SCAN_LIMIT) begin
            @(negedge clk);
            n++;
            if (an != '1) begin
                k = 0;
                for (int j = 3; j >= 0; j--) begin
                    if (!an[j]) k = j;
                end
                exp_an    = '1;
                exp_an[k] = 1'b0;
                check_seg($sformatf("digit %0d", k), seg, an,
                          seg_pattern(seg7_model[k*4 +: 4]), exp_an);
                seen[k] = 1'b1;
            end
        end
        if (seen != 4'hF) begin
            abort_run("the display scan did not reach all four digits");
        end else begin
            finish_test();
        end

        start_test("unmapped addresses");
        foreach (holes[i]) begin
            bus_write(holes[i], $urandom);
            bus_read(holes[i]);
        end
        foreach (ram_adrs[i]) begin
            bus_read(ram_adrs[i]);
        end
        check_ctl("register outputs after unmapped writes", video_ctl, cursor_col, cursor_row);
        for (int i = 0; i < 3; i++) begin
            bus_read(soc_map_pkg::VIDEO_ADDR + soc_types_pkg::addr_t'(i));
        end
        bus_read(soc_map_pkg::SEG7_ADDR);
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/soc_map_pkg.sv
common/soc_types_pkg.sv
src/bus_decode.sv
src/data_ram.sv
src/mmr.sv
src/text_ram.sv
seg7/seg7_driver.sv
src/periph_top.sv
bench/periph_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = periph_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
